/* bench/sb_subsystem_patterns.txt */
# Columns are write flag, address, write data, expected data and expected error, all in hex
# Each line is one host request and the one response that must come back for it
# Register bank reads back zero after reset
0 00000000 00000000 00000000 0
0 00000004 00000000 00000000 0
0 00000008 00000000 00000000 0
0 0000000c 00000000 00000000 0
0 00000010 00000000 00000000 0
0 00000014 00000000 00000000 0
0 00000018 00000000 00000000 0
0 0000001c 00000000 00000000 0
0 00000020 00000000 00000000 0
0 00000024 00000000 00000000 0
0 00000028 00000000 00000000 0
0 0000002c 00000000 00000000 0
0 00000030 00000000 00000000 0
0 00000034 00000000 00000000 0
0 00000038 00000000 00000000 0
0 0000003c 00000000 00000000 0
# Mailbox status after reset shows only the empty bit
0 00001004 00000000 00000010 0
# Register writes land in their own word and leave neighbors alone
1 00000004 a5a50004 00000000 0
1 00000008 5a5a0008 00000000 0
1 0000003c c0de003c 00000000 0
0 00000000 00000000 00000000 0
0 00000004 00000000 a5a50004 0
0 00000008 00000000 5a5a0008 0
0 0000000c 00000000 00000000 0
0 00000038 00000000 00000000 0
0 0000003c 00000000 c0de003c 0
# Mailbox fills up, count follows the pushes
1 00001000 11110001 00000000 0
1 00001000 11110002 00000000 0
1 00001000 11110003 00000000 0
0 00001004 00000000 00000003 0
1 00001000 11110004 00000000 0
1 00001000 11110005 00000000 0
1 00001000 11110006 00000000 0
1 00001000 11110007 00000000 0
1 00001000 11110008 00000000 0
0 00001004 00000000 00000028 0
# A ninth push is refused after the wait limit
1 00001000 11110009 00000000 1
# Pops return the first eight words in order
0 00001000 00000000 11110001 0
0 00001000 00000000 11110002 0
0 00001000 00000000 11110003 0
0 00001000 00000000 11110004 0
0 00001004 00000000 00000004 0
0 00001000 00000000 11110005 0
0 00001000 00000000 11110006 0
0 00001000 00000000 11110007 0
0 00001000 00000000 11110008 0
# Pop from empty gives zero and sets underflow, the clear register resets status
0 00001000 00000000 00000000 0
0 00001004 00000000 00000050 0
1 00001008 00000000 00000000 0
0 00001004 00000000 00000010 0
# Unmapped reads answer with an error and zero data
0 00002000 00000000 00000000 1
0 00000040 00000000 00000000 1
0 00001010 00000000 00000000 1

/* bench/sb_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_subsystem_tb;
    import simplebus_pkg::*;

    localparam string PATTERN_FILE = "bench/sb_subsystem_patterns.txt";
    localparam int RESET_CYCLES = 8;
    // Budget for one request including idle gaps and the longest wait in the host port
    localparam int CYCLES_PER_PATTERN = 20;
    localparam int TIMEOUT_MARGIN = 50;
    localparam logic [31:0] LFSR_SEED = 32'h13c1a30b;

    // One line of the pattern file, the request and the response it must produce
    typedef struct packed {
        logic     write;
        sb_addr_t address;
        sb_data_t write_data;
        sb_data_t expected_data;
        logic     expected_error;
    } pattern_t;

    logic       clock;
    logic       reset;
    host_req_t  host_request;
    logic       host_request_strobe;
    logic       host_busy;
    host_resp_t host_response;
    logic       host_response_valid;

    pattern_t patterns[$];
    logic [31:0] lfsr_state = LFSR_SEED;
    int cycle_count = 0;
    // Stays zero until the patterns are loaded and the run length is known
    int cycle_limit = 0;

    sb_subsystem i_sb_subsystem (
        .clock               (clock),
        .reset               (reset),
        .host_request        (host_request),
        .host_request_strobe (host_request_strobe),
        .host_busy           (host_busy),
        .host_response       (host_response),
        .host_response_valid (host_response_valid)
    );

    // 20 ns clock period
    always #10 clock = ~clock;

    // Run length guard, a missing response ends the run here
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("No response arrived from the DUT within %0d cycles", cycle_limit);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        logic feedback;
        feedback = value[31] ^ value[21] ^ value[1] ^ value[0];
        return {value[30:0], feedback};
    endfunction

    // One step of the generator for every bit that is used
    function automatic logic take_random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    task automatic check_data(input sb_data_t actual, input sb_data_t expected,
                              input int index);
        if (actual !== expected) begin
            $display("error at time %0t: pattern %0d returned data %h, expected %h",
                     $time, index, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_error(input logic actual, input logic expected, input int index);
        if (actual !== expected) begin
            $display("error at time %0t: pattern %0d returned error flag %b, expected %b",
                     $time, index, actual, expected);
            stop_on_failure();
        end
    endtask

    // Busy and response-valid levels seen around one transaction
    task automatic check_handshake(input logic actual, input logic expected,
                                   input string signal_name, input int index);
        if (actual !== expected) begin
            $display("error at time %0t: pattern %0d saw %s at %b, expected %b",
                     $time, index, signal_name, actual, expected);
            stop_on_failure();
        end
    endtask

    // Lines starting with a hash are comments, every other line holds five hex fields
    task automatic load_patterns();
        int file_handle;
        int read_count;
        int field_count;
        string line;
        logic [31:0] write_field;
        logic [31:0] address_field;
        logic [31:0] write_data_field;
        logic [31:0] expected_data_field;
        logic [31:0] error_field;
        pattern_t pattern;
        file_handle = $fopen(PATTERN_FILE, "r");
        if (file_handle == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            stop_on_failure();
        end else begin
            while (!$feof(file_handle)) begin
                line = "";
                read_count = $fgets(line, file_handle);
                if (read_count > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    field_count = $sscanf(line, "%h %h %h %h %h", write_field, address_field,
                                          write_data_field, expected_data_field, error_field);
                    if (field_count == 5) begin
                        pattern.write = write_field[0];
                        pattern.address = address_field;
                        pattern.write_data = write_data_field;
                        pattern.expected_data = expected_data_field;
                        pattern.expected_error = error_field[0];
                        patterns.push_back(pattern);
                    end else begin
                        $display("Malformed line in the pattern file: %s", line);
                        stop_on_failure();
                    end
                end
            end
            $fclose(file_handle);
        end
    endtask

    // Issues one request when the port is free and checks the single response
    task automatic run_pattern(input pattern_t pattern, input int index);
        int idle_cycles;
        logic high_bit;
        logic low_bit;
        high_bit = take_random_bit();
        low_bit = take_random_bit();
        idle_cycles = int'({high_bit, low_bit});
        repeat (idle_cycles) @(posedge clock);
        // Sampled values at the edge belong to the cycle before it
        @(posedge clock);
        while (host_busy) begin
            @(posedge clock);
        end
        host_request <= '{write: pattern.write, address: pattern.address,
                          data: pattern.write_data};
        host_request_strobe <= 1'b1;
        @(posedge clock);
        // The port takes the request at this edge, so the strobe lasts one cycle
        host_request_strobe <= 1'b0;
        @(posedge clock);
        // Busy holds from acceptance through the cycle of the response pulse
        while (!host_response_valid) begin
            check_handshake(host_busy, 1'b1, "host_busy", index);
            @(posedge clock);
        end
        check_handshake(host_busy, 1'b1, "host_busy", index);
        check_data(host_response.data, pattern.expected_data, index);
        check_error(host_response.error, pattern.expected_error, index);
        // The response pulse lasts one cycle and the port is free right after it
        @(posedge clock);
        check_handshake(host_response_valid, 1'b0, "host_response_valid", index);
        check_handshake(host_busy, 1'b0, "host_busy", index);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        host_request = '0;
        host_request_strobe = 1'b0;
        load_patterns();
        if (patterns.size() == 0) begin
            $display("The pattern file holds no patterns");
            stop_on_failure();
        end
        cycle_limit = patterns.size() * CYCLES_PER_PATTERN + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < patterns.size(); i++) begin
            run_pattern(patterns[i], i);
        end
        $display("%0d patterns run in %0d cycles", patterns.size(), cycle_count);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/sb_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_host_port (
    input  logic                       clock,
    input  logic                       reset,
    input  simplebus_pkg::host_req_t   host_request,
    input  logic                       host_request_strobe,
    output logic                       host_busy,
    output simplebus_pkg::host_resp_t  host_response,
    output logic                       host_response_valid,
    output simplebus_pkg::sb_request_t master_request,
    input  simplebus_pkg::sb_response_t master_response
);
    import simplebus_pkg::*;

    host_state_t state;
    host_count_t wait_count;
    // Direction of the request being served
    logic pending_write;

    // Busy covers the whole transaction and the cycle of the response pulse
    assign host_busy = (state != HOST_IDLE) || host_response_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= HOST_IDLE;
            wait_count <= '0;
            pending_write <= 1'b0;
            master_request <= '0;
            host_response <= '0;
            host_response_valid <= 1'b0;
        end else begin
            // Strobes and the response flag are single cycle pulses
            master_request.write_strobe <= 1'b0;
            master_request.read_strobe <= 1'b0;
            host_response_valid <= 1'b0;
            case (state)
                HOST_IDLE: begin
                    if (host_request_strobe) begin
                        // Address and data are held on the bus for the whole transaction
                        master_request.address <= host_request.address;
                        master_request.write_data <= host_request.data;
                        pending_write <= host_request.write;
                        wait_count <= '0;
                        state <= HOST_WAIT_READY;
                    end
                end
                HOST_WAIT_READY: begin
                    // Back-pressure holds off writes only, so a full mailbox can still drain
                    if (master_response.ready || !pending_write) begin
                        master_request.write_strobe <= pending_write;
                        master_request.read_strobe <= !pending_write;
                        wait_count <= '0;
                        state <= pending_write ? HOST_SETTLE : HOST_WAIT_READ;
                    end else if (wait_count == host_count_t'(HOST_WAIT_LIMIT - 1)) begin
                        // Slave stayed busy too long, give up without a strobe
                        host_response <= '{data: '0, error: 1'b1};
                        host_response_valid <= 1'b1;
                        state <= HOST_IDLE;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                HOST_WAIT_READ: begin
                    if (master_response.read_valid) begin
                        host_response <= '{data: master_response.read_data, error: 1'b0};
                        host_response_valid <= 1'b1;
                        state <= HOST_IDLE;
                    end else if (wait_count == host_count_t'(HOST_WAIT_LIMIT - 1)) begin
                        // No slave answered, the address is unmapped
                        host_response <= '{data: '0, error: 1'b1};
                        host_response_valid <= 1'b1;
                        state <= HOST_IDLE;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                HOST_SETTLE: begin
                    // Wait for the write to land and the new ready to come back
                    if (wait_count == host_count_t'(HOST_SETTLE_CYCLES - 1)) begin
                        host_response <= '{data: '0, error: 1'b0};
                        host_response_valid <= 1'b1;
                        state <= HOST_IDLE;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                default: begin
                    state <= HOST_IDLE;
                end
            endcase
        end
    end

    // One transaction direction at a time on the bus
    strobe_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(master_request.write_strobe && master_request.read_strobe));

endmodule

`default_nettype wire

/* hw/sb_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_interconnect (
    input  logic                        clock,
    input  logic                        reset,
    input  simplebus_pkg::sb_request_t  master_request,
    output simplebus_pkg::sb_response_t master_response,
    output simplebus_pkg::sb_request_t  slave_1_request,
    input  simplebus_pkg::sb_response_t slave_1_response,
    output simplebus_pkg::sb_request_t  slave_2_request,
    input  simplebus_pkg::sb_response_t slave_2_response
);
    import simplebus_pkg::*;

    logic slave_1_hit;
    logic slave_2_hit;
    logic slave_1_strobe;
    logic slave_2_strobe;

    // Slave 1 is the register bank window
    assign slave_1_hit = (master_request.address >= REGBANK_LOW)
                      && (master_request.address < REGBANK_HIGH);
    // Slave 2 is the mailbox window
    assign slave_2_hit = (master_request.address >= MAILBOX_LOW)
                      && (master_request.address < MAILBOX_HIGH);

    // Forward path, one register stage
    always_ff @(posedge clock) begin
        if (reset) begin
            slave_1_request <= '0;
            slave_2_request <= '0;
        end else begin
            // A slave outside the decoded window sees an all zero request
            if (slave_1_hit) begin
                slave_1_request <= master_request;
            end else begin
                slave_1_request <= '0;
            end
            if (slave_2_hit) begin
                slave_2_request <= master_request;
            end else begin
                slave_2_request <= '0;
            end
        end
    end

    // Return path, one register stage
    always_ff @(posedge clock) begin
        if (reset) begin
            master_response <= SB_RESPONSE_IDLE;
        end else begin
            // Idle slaves return zero data, so an OR merges the two read paths
            master_response.read_data <= slave_1_response.read_data
                                       | slave_2_response.read_data;
            master_response.read_valid <= slave_1_response.read_valid
                                        | slave_2_response.read_valid;
            // Any busy slave stalls the master
            master_response.ready <= slave_1_response.ready & slave_2_response.ready;
        end
    end

    assign slave_1_strobe = slave_1_request.write_strobe || slave_1_request.read_strobe;
    assign slave_2_strobe = slave_2_request.write_strobe || slave_2_request.read_strobe;

    // The windows do not overlap so a strobe reaches at most one slave
    single_target: assert property (@(posedge clock) disable iff (reset)
        !(slave_1_strobe && slave_2_strobe));

endmodule

`default_nettype wire

/* hw/sb_mailbox.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_mailbox (
    input  logic                        clock,
    input  logic                        reset,
    input  simplebus_pkg::sb_request_t  bus_request,
    output simplebus_pkg::sb_response_t bus_response
);
    import simplebus_pkg::*;

    sb_data_t fifo_storage [MAILBOX_DEPTH];
    mailbox_ptr_t write_ptr;
    mailbox_ptr_t read_ptr;
    mailbox_count_t count;
    mailbox_count_t count_next;
    mailbox_offset_t offset;
    logic underflow;
    logic empty;
    logic full;
    logic data_write;
    logic data_read;
    logic clear;
    logic push;
    logic pop;
    sb_data_t status;

    assign offset = bus_request.address[SB_WORD_SHIFT +: $bits(mailbox_offset_t)];

    assign empty = (count == '0);
    assign full = (count == mailbox_count_t'(MAILBOX_DEPTH));

    // Decoded accesses to the data and clear registers
    assign data_write = bus_request.write_strobe && (offset == MAILBOX_DATA_OFFSET);
    assign data_read = bus_request.read_strobe && (offset == MAILBOX_DATA_OFFSET);
    assign clear = bus_request.write_strobe && (offset == MAILBOX_CLEAR_OFFSET);
    // Guard the FIFO even though the master respects ready
    assign push = data_write && !full;
    assign pop = data_read && !empty;

    // Status word, count in the low bits then empty, full and underflow
    assign status = sb_data_t'({underflow, full, empty, count});

    always_comb begin
        if (clear) begin
            count_next = '0;
        end else begin
            count_next = count + mailbox_count_t'(push) - mailbox_count_t'(pop);
        end
    end

    // Storage, written only on a push
    always_ff @(posedge clock) begin
        if (push) begin
            fifo_storage[write_ptr] <= bus_request.write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
            underflow <= 1'b0;
            bus_response <= SB_RESPONSE_IDLE;
        end else begin
            count <= count_next;
            // Ready follows the new fill level at the same edge
            bus_response.ready <= (count_next != mailbox_count_t'(MAILBOX_DEPTH));
            bus_response.read_valid <= bus_request.read_strobe;
            if (clear) begin
                write_ptr <= '0;
                read_ptr <= '0;
                underflow <= 1'b0;
            end else begin
                // Pointers wrap naturally since the depth is a power of two
                if (push) begin
                    write_ptr <= write_ptr + 1'b1;
                end
                if (pop) begin
                    read_ptr <= read_ptr + 1'b1;
                end
                // Sticky until the clear register is written
                if (data_read && empty) begin
                    underflow <= 1'b1;
                end
            end
            // Reads return zero unless a register is selected
            bus_response.read_data <= '0;
            if (bus_request.read_strobe) begin
                case (offset)
                    MAILBOX_DATA_OFFSET: begin
                        bus_response.read_data <= pop ? fifo_storage[read_ptr] : '0;
                    end
                    MAILBOX_STATUS_OFFSET: begin
                        bus_response.read_data <= status;
                    end
                    default: begin
                        bus_response.read_data <= '0;
                    end
                endcase
            end
        end
    end

    // The host withholds writes while ready is low, so a full FIFO never sees a push
    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        !(data_write && full));

endmodule

`default_nettype wire

/* hw/sb_register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_register_bank (
    input  logic                        clock,
    input  logic                        reset,
    input  simplebus_pkg::sb_request_t  bus_request,
    output simplebus_pkg::sb_response_t bus_response
);
    import simplebus_pkg::*;

    sb_data_t registers [REGBANK_WORDS];
    regbank_index_t index;

    // Word index taken from the bits above the byte offset
    assign index = bus_request.address[SB_WORD_SHIFT +: REGBANK_INDEX_WIDTH];

    // Register contents, cleared by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < REGBANK_WORDS; i++) begin
                registers[i] <= '0;
            end
        end else if (bus_request.write_strobe) begin
            // Write lands at the strobe edge
            registers[index] <= bus_request.write_data;
        end
    end

    // Read return, one cycle after the strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            bus_response <= SB_RESPONSE_IDLE;
        end else begin
            // The bank never stalls
            bus_response.ready <= 1'b1;
            bus_response.read_valid <= bus_request.read_strobe;
            // Data stays zero outside the read-valid pulse for the OR merge upstream
            if (bus_request.read_strobe) begin
                bus_response.read_data <= registers[index];
            end else begin
                bus_response.read_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sb_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_subsystem (
    input  logic                      clock,
    input  logic                      reset,
    input  simplebus_pkg::host_req_t  host_request,
    input  logic                      host_request_strobe,
    output logic                      host_busy,
    output simplebus_pkg::host_resp_t host_response,
    output logic                      host_response_valid
);
    import simplebus_pkg::*;

    // Host port to interconnect
    sb_request_t  master_request;
    sb_response_t master_response;
    // Interconnect to register bank
    sb_request_t  slave_1_request;
    sb_response_t slave_1_response;
    // Interconnect to mailbox
    sb_request_t  slave_2_request;
    sb_response_t slave_2_response;

    sb_host_port i_host_port (
        .clock               (clock),
        .reset               (reset),
        .host_request        (host_request),
        .host_request_strobe (host_request_strobe),
        .host_busy           (host_busy),
        .host_response       (host_response),
        .host_response_valid (host_response_valid),
        .master_request      (master_request),
        .master_response     (master_response)
    );

    sb_interconnect i_interconnect (
        .clock            (clock),
        .reset            (reset),
        .master_request   (master_request),
        .master_response  (master_response),
        .slave_1_request  (slave_1_request),
        .slave_1_response (slave_1_response),
        .slave_2_request  (slave_2_request),
        .slave_2_response (slave_2_response)
    );

    sb_register_bank i_register_bank (
        .clock        (clock),
        .reset        (reset),
        .bus_request  (slave_1_request),
        .bus_response (slave_1_response)
    );

    sb_mailbox i_mailbox (
        .clock        (clock),
        .reset        (reset),
        .bus_request  (slave_2_request),
        .bus_response (slave_2_response)
    );

endmodule

`default_nettype wire

/* hw/simplebus_pkg.sv */
`default_nettype none

package simplebus_pkg;

    // Bus widths shared by every block on the simple bus
    localparam int SB_ADDR_WIDTH = 32;
    localparam int SB_DATA_WIDTH = 32;
    // Byte address bits below the word index
    localparam int SB_WORD_SHIFT = 2;

    typedef logic [SB_ADDR_WIDTH-1:0] sb_addr_t;
    typedef logic [SB_DATA_WIDTH-1:0] sb_data_t;

    // Address map, each window is a half-open range [low, high)
    localparam sb_addr_t REGBANK_LOW = 32'h0000_0000;
    localparam sb_addr_t REGBANK_HIGH = 32'h0000_0040;
    localparam sb_addr_t MAILBOX_LOW = 32'h0000_1000;
    localparam sb_addr_t MAILBOX_HIGH = 32'h0000_1010;

    // Register bank geometry
    localparam int REGBANK_WORDS = 16;
    localparam int REGBANK_INDEX_WIDTH = $clog2(REGBANK_WORDS);
    typedef logic [REGBANK_INDEX_WIDTH-1:0] regbank_index_t;

    // Mailbox FIFO geometry, the count needs one more bit than the pointers
    localparam int MAILBOX_DEPTH = 8;
    localparam int MAILBOX_PTR_WIDTH = $clog2(MAILBOX_DEPTH);
    localparam int MAILBOX_COUNT_WIDTH = $clog2(MAILBOX_DEPTH + 1);
    typedef logic [MAILBOX_PTR_WIDTH-1:0] mailbox_ptr_t;
    typedef logic [MAILBOX_COUNT_WIDTH-1:0] mailbox_count_t;

    // Word offsets inside the mailbox window
    typedef logic [1:0] mailbox_offset_t;
    localparam mailbox_offset_t MAILBOX_DATA_OFFSET = 2'd0;
    localparam mailbox_offset_t MAILBOX_STATUS_OFFSET = 2'd1;
    localparam mailbox_offset_t MAILBOX_CLEAR_OFFSET = 2'd2;

    // Host port timing, the counter covers the longest wait
    localparam int HOST_WAIT_LIMIT = 8;
    localparam int HOST_SETTLE_CYCLES = 3;
    localparam int HOST_COUNT_WIDTH = $clog2(HOST_WAIT_LIMIT);
    typedef logic [HOST_COUNT_WIDTH-1:0] host_count_t;

    // Master to slave strobes and payload
    typedef struct packed {
        sb_addr_t address;
        logic     write_strobe;
        logic     read_strobe;
        sb_data_t write_data;
    } sb_request_t;

    // Slave to master return path
    typedef struct packed {
        sb_data_t read_data;
        logic     read_valid;
        logic     ready;
    } sb_response_t;

    // Value of a return path at rest, ready with no data
    localparam sb_response_t SB_RESPONSE_IDLE = '{read_data: '0, read_valid: 1'b0, ready: 1'b1};

    typedef struct packed {
        logic     write;
        sb_addr_t address;
        sb_data_t data;
    } host_req_t;

    typedef struct packed {
        sb_data_t data;
        logic     error;
    } host_resp_t;

    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_WAIT_READY,
        HOST_WAIT_READ,
        HOST_SETTLE
    } host_state_t;

endpackage

`default_nettype wire

/* sb_subsystem.f */
hw/simplebus_pkg.sv
hw/sb_host_port.sv
hw/sb_interconnect.sv
hw/sb_register_bank.sv
hw/sb_mailbox.sv
hw/sb_subsystem.sv
bench/sb_subsystem_tb.sv
